// ==== project.f ====
dmem_pkg.sv
access_steer.sv
byte_bank.sv
load_unit.sv
data_mem.sv
clk_gen.sv
dmem_props.sv
tb_dmem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dmem
RTL_TOP   ?= data_mem
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter %.sv,$(shell cat $(FILE_LIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_dmem.sv ====
`timescale 1ns/100ps

module tb_dmem import dmem_pkg::*; ();

    localparam int ADDR_W         = 11;
    localparam int MEM_BYTES      = 1 << ADDR_W;
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int DIRECTED_STEPS = 100; // Upper bound on directed requests
    localparam int NUM_RANDOM     = 400;
    localparam int WATCHDOG_NS    =
        (2 * RESET_CYCLES + DIRECTED_STEPS + NUM_RANDOM) * CLK_PERIOD + 2000;

    logic              clk;
    logic              reset;
    logic              store_en;
    logic [ADDR_W-1:0] store_addr;
    logic [2:0]        store_funct3;
    logic [31:0]       store_data;
    logic              ls_read;
    logic [ADDR_W-1:0] ls_addr;
    logic [2:0]        ls_funct3;
    logic              rob_read;
    logic [ADDR_W-1:0] rob_addr;
    logic [2:0]        rob_funct3;
    logic [31:0]       rob_value;
    logic [31:0]       load_data;
    logic              exception;

    logic [7:0]  shadow [MEM_BYTES];         // Byte-level reference memory
    logic [15:0] lfsr_state = 16'd14;
    logic [2:0]  load_codes [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
    string       test_name;
    int          errors = 0;
    int          checks = 0;

    clk_gen #(.PERIOD_NS (CLK_PERIOD)) u_clk (.clk (clk));

    data_mem #(
        .ADDR_W (ADDR_W)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .store_en     (store_en),
        .store_addr   (store_addr),
        .store_funct3 (store_funct3),
        .store_data   (store_data),
        .ls_read      (ls_read),
        .ls_addr      (ls_addr),
        .ls_funct3    (ls_funct3),
        .rob_read     (rob_read),
        .rob_addr     (rob_addr),
        .rob_funct3   (rob_funct3),
        .rob_value    (rob_value),
        .load_data    (load_data),
        .exception    (exception)
    );

    // RISC-V load rules on the byte model with wraparound at the top
    function automatic logic [31:0] model_load(
        input logic [ADDR_W-1:0] addr,
        input logic [2:0]        funct3
    );
        logic [7:0]        b [4];
        logic [ADDR_W-1:0] a;
        logic [31:0]       v;
        a = addr;
        for (int k = 0; k < 4; k++) begin
            b[k] = shadow[a];
            a    = a + ADDR_W'(1);
        end
        case (funct3)
            F3_B:    v = {{24{b[0][7]}}, b[0]};
            F3_H:    v = {{16{b[1][7]}}, b[1], b[0]};
            F3_W:    v = {b[3], b[2], b[1], b[0]};
            F3_BU:   v = {24'h000000, b[0]};
            F3_HU:   v = {16'h0000, b[1], b[0]};
            default: v = 32'h00000000;
        endcase
        return v;
    endfunction

    task automatic model_store(
        input logic [ADDR_W-1:0] addr,
        input logic [2:0]        funct3,
        input logic [31:0]       data
    );
        logic [ADDR_W-1:0] a;
        int                nbytes;
        a = addr;
        case (funct3)
            F3_B:    nbytes = 1;
            F3_H:    nbytes = 2;
            F3_W:    nbytes = 4;
            default: nbytes = 0;    // Unknown size leaves memory alone
        endcase
        for (int k = 0; k < nbytes; k++) begin
            shadow[a] = data[8*k +: 8];
            a         = a + ADDR_W'(1);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'h00000000;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Low 64 or top 64 bytes so that accesses collide and wrap
    task automatic rand_addr(output logic [ADDR_W-1:0] addr);
        logic [31:0] r;
        rand_bits(7, r);
        addr = {{(ADDR_W-6){r[6]}}, r[5:0]};
    endtask

    task automatic idle_inputs();
        store_en     = 1'b0;
        store_addr   = '0;
        store_funct3 = F3_B;
        store_data   = 32'h00000000;
        ls_read      = 1'b0;
        ls_addr      = '0;
        ls_funct3    = F3_B;
        rob_read     = 1'b0;
        rob_addr     = '0;
        rob_funct3   = F3_B;
        rob_value    = 32'h00000000;
    endtask

    // Full reset period, the model is cleared along with the banks
    task automatic apply_reset();
        idle_inputs();
        reset = 1'b1;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // Expected values come from the model before this edge's store lands
    task automatic step();
        logic [31:0] exp_load;
        logic        exp_exc;
        exp_load = ls_read ? model_load(ls_addr, ls_funct3) : 32'h00000000;
        exp_exc  = rob_read && (model_load(rob_addr, rob_funct3) != rob_value);
        @(posedge clk);
        if (store_en) begin
            model_store(store_addr, store_funct3, store_data);
        end
        #1;
        checks += 2;
        assert (load_data === exp_load) else begin
            $display("Fail %s load_data expected %h actual %h",
                     test_name, exp_load, load_data);
            errors++;
        end
        assert (exception === exp_exc) else begin
            $display("Fail %s exception expected %b actual %b",
                     test_name, exp_exc, exception);
            errors++;
        end
    endtask

    task automatic do_store(input logic [ADDR_W-1:0] addr, input logic [2:0] f3,
                            input logic [31:0] data);
        idle_inputs();
        store_en     = 1'b1;
        store_addr   = addr;
        store_funct3 = f3;
        store_data   = data;
        step();
    endtask

    task automatic do_load(input logic [ADDR_W-1:0] addr, input logic [2:0] f3);
        idle_inputs();
        ls_read   = 1'b1;
        ls_addr   = addr;
        ls_funct3 = f3;
        step();
    endtask

    task automatic do_commit(input logic [ADDR_W-1:0] addr, input logic [2:0] f3,
                             input logic [31:0] value);
        idle_inputs();
        rob_read   = 1'b1;
        rob_addr   = addr;
        rob_funct3 = f3;
        rob_value  = value;
        step();
    endtask

    task automatic idle_step();
        idle_inputs();
        step();
    endtask

    task automatic random_request();
        logic [31:0] r;
        logic [31:0] data;
        idle_inputs();
        rand_bits(1, r);
        store_en = r[0];
        rand_addr(store_addr);
        rand_bits(3, r);
        store_funct3 = r[2:0];
        rand_bits(32, data);
        store_data = data;
        rand_bits(1, r);
        ls_read = r[0];
        rand_addr(ls_addr);
        rand_bits(3, r);
        ls_funct3 = r[2:0];
        rand_bits(1, r);
        rob_read = r[0];
        rand_addr(rob_addr);
        rand_bits(3, r);
        rob_funct3 = r[2:0];
        rand_bits(1, r);
        if (r[0]) begin
            rob_value = model_load(rob_addr, rob_funct3); // Matching commit
        end else begin
            rand_bits(32, data);
            rob_value = data;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] v;
        apply_reset();

        test_name = "reset_clear";
        // Nonzero words under every address read after the second reset
        do_store(11'h000, F3_W, 32'hDEADBEEF);
        do_store(11'h004, F3_W, 32'h5EC0DE17);
        do_store(11'h008, F3_W, 32'h7E57AB1E);
        do_store(11'h3FC, F3_W, 32'h0BADF00D);
        do_store(11'h400, F3_W, 32'h13579BDF);
        do_store(11'h404, F3_W, 32'h2468ACE0);
        do_store(11'h7FC, F3_W, 32'hFEEDC0DE);
        idle_inputs();
        ls_read    = 1'b1;
        ls_addr    = 11'h000;
        ls_funct3  = F3_W;
        rob_read   = 1'b1;
        rob_addr   = 11'h000;
        rob_funct3 = F3_W;
        rob_value  = 32'h00000000;
        step();                                  // Both outputs busy going into reset
        apply_reset();
        do_load(11'h000, F3_W);
        do_load(11'h003, F3_W);
        do_load(11'h3FE, F3_W);
        do_load(11'h7FF, F3_W);
        do_load(11'h401, F3_W);
        do_commit(11'h006, F3_W, 32'h00000000);

        test_name = "aligned";
        do_store(11'h010, F3_W, 32'h876543A1);
        for (int i = 0; i < 5; i++) begin
            do_load(11'h010, load_codes[i]);
        end
        do_load(11'h013, F3_B);
        do_load(11'h013, F3_BU);
        do_load(11'h012, F3_H);
        do_load(11'h012, F3_HU);
        do_store(11'h020, F3_H, 32'h1234F00D);
        do_load(11'h020, F3_H);
        do_load(11'h020, F3_HU);
        do_load(11'h020, F3_W);
        do_store(11'h028, F3_B, 32'hFFFFFF80);
        do_load(11'h028, F3_B);
        do_load(11'h028, F3_BU);

        test_name = "unaligned";
        do_store(11'h103, F3_W, 32'hC0DE9A5B);  // Offset 3 spills into the next word
        do_load(11'h103, F3_W);
        do_load(11'h103, F3_H);
        do_load(11'h104, F3_HU);
        do_load(11'h105, F3_H);
        do_load(11'h101, F3_W);
        do_load(11'h102, F3_W);
        do_store(11'h10B, F3_H, 32'h0000BEEF);
        do_load(11'h108, F3_W);
        do_load(11'h10B, F3_H);
        do_store(11'h7FF, F3_W, 32'hA1B2C3D4);  // Wraps to address 0
        do_load(11'h7FF, F3_W);
        do_load(11'h000, F3_W);
        do_load(11'h7FF, F3_H);
        do_load(11'h7FF, F3_B);
        do_load(11'h002, F3_BU);
        do_store(11'h7FF, F3_H, 32'h00008E71);
        do_load(11'h7FF, F3_HU);

        test_name = "commit_check";
        do_store(11'h200, F3_W, 32'h5A5AF00F);
        v = model_load(11'h200, F3_W);
        do_commit(11'h200, F3_W, v);
        do_commit(11'h200, F3_W, v ^ 32'h00000020);
        idle_step();
        v = model_load(11'h201, F3_H);
        do_commit(11'h201, F3_H, v);
        do_commit(11'h201, F3_H, v ^ 32'h00000001);
        idle_step();
        v = model_load(11'h203, F3_BU);
        do_commit(11'h203, F3_BU, v ^ 32'h80000000);
        idle_step();

        test_name = "same_edge";
        do_store(11'h300, F3_W, 32'h11223344);
        idle_inputs();
        store_en     = 1'b1;
        store_addr   = 11'h300;
        store_funct3 = F3_W;
        store_data   = 32'hCAFE0099;
        ls_read      = 1'b1;
        ls_addr      = 11'h300;
        ls_funct3    = F3_W;
        step();
        do_load(11'h300, F3_W);
        idle_inputs();
        store_en     = 1'b1;
        store_addr   = 11'h302;
        store_funct3 = F3_B;
        store_data   = 32'h000000E7;
        ls_read      = 1'b1;
        ls_addr      = 11'h302;
        ls_funct3    = F3_BU;
        step();
        do_load(11'h302, F3_BU);

        test_name = "random_mix";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_request();
            step();
        end
        idle_step();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dmem_props.sv ====
`timescale 1ns/100ps

module dmem_props import dmem_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        ls_read,
    input logic [2:0]  ls_funct3,
    input logic        rob_read,
    input logic [31:0] load_data,
    input logic        exception
);

    // No commit request, no exception in the next cycle
    assert property (@(posedge clk) disable iff (reset)
        !rob_read |=> !exception)
        else $error("exception high after a cycle without rob_read");

    // Idle load port returns zero
    assert property (@(posedge clk) disable iff (reset)
        !ls_read |=> (load_data == 32'h00000000))
        else $error("load_data not zero after a cycle without ls_read");

    assert property (@(posedge clk) disable iff (reset)
        (ls_read && ls_funct3 == F3_BU) |=> (load_data[31:8] == 24'h000000))
        else $error("upper bits of load_data not zero after LBU");

    // Both registers cleared by reset
    assert property (@(posedge clk)
        reset |=> (load_data == 32'h00000000 && exception == 1'b0))
        else $error("outputs not cleared after reset");

endmodule

bind data_mem dmem_props u_props (
    .clk       (clk),
    .reset     (reset),
    .ls_read   (ls_read),
    .ls_funct3 (ls_funct3),
    .rob_read  (rob_read),
    .load_data (load_data),
    .exception (exception)
);

// ==== clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk; // Free-running, 50% duty

endmodule

// ==== data_mem.sv ====
`timescale 1ns/100ps

module data_mem import dmem_pkg::*; #(
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              store_en,
    input  logic [ADDR_W-1:0] store_addr,
    input  logic [2:0]        store_funct3,
    input  logic [31:0]       store_data,
    input  logic              ls_read,
    input  logic [ADDR_W-1:0] ls_addr,
    input  logic [2:0]        ls_funct3,
    input  logic              rob_read,
    input  logic [ADDR_W-1:0] rob_addr,
    input  logic [2:0]        rob_funct3,
    input  logic [31:0]       rob_value,
    output logic [31:0]       load_data,
    output logic              exception
);

    localparam int IDX_W = ADDR_W - 2;

    logic [NUM_LANES-1:0]            wr_en;
    logic [NUM_LANES-1:0][IDX_W-1:0] wr_index;
    logic [NUM_LANES-1:0][7:0]       wr_byte;
    logic [NUM_LANES-1:0][IDX_W-1:0] ls_index;
    logic [NUM_LANES-1:0][IDX_W-1:0] rob_index;
    logic [NUM_LANES-1:0][7:0]       ls_bytes;
    logic [NUM_LANES-1:0][7:0]       rob_bytes;

    access_steer #(
        .ADDR_W (ADDR_W)
    ) u_steer (
        .store_en     (store_en),
        .store_addr   (store_addr),
        .store_funct3 (store_funct3),
        .store_data   (store_data),
        .ls_addr      (ls_addr),
        .rob_addr     (rob_addr),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_byte      (wr_byte),
        .ls_index     (ls_index),
        .rob_index    (rob_index)
    );

    // One bank per byte lane
    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_bank
        byte_bank #(
            .IDX_W (IDX_W)
        ) u_bank (
            .clk        (clk),
            .reset      (reset),
            .wr_en      (wr_en[lane]),
            .wr_index   (wr_index[lane]),
            .wr_byte    (wr_byte[lane]),
            .rd_index_a (ls_index[lane]),
            .rd_index_b (rob_index[lane]),
            .rd_byte_a  (ls_bytes[lane]),
            .rd_byte_b  (rob_bytes[lane])
        );
    end

    load_unit #(
        .ADDR_W (ADDR_W)
    ) u_load (
        .clk        (clk),
        .reset      (reset),
        .ls_read    (ls_read),
        .ls_addr    (ls_addr),
        .ls_funct3  (ls_funct3),
        .ls_bytes   (ls_bytes),
        .rob_read   (rob_read),
        .rob_addr   (rob_addr),
        .rob_funct3 (rob_funct3),
        .rob_value  (rob_value),
        .rob_bytes  (rob_bytes),
        .load_data  (load_data),
        .exception  (exception)
    );

endmodule

// ==== load_unit.sv ====
`timescale 1ns/100ps

module load_unit import dmem_pkg::*; #(
    parameter int ADDR_W = 11
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ls_read,
    input  logic [ADDR_W-1:0]         ls_addr,
    input  logic [2:0]                ls_funct3,
    input  logic [NUM_LANES-1:0][7:0] ls_bytes,
    input  logic                      rob_read,
    input  logic [ADDR_W-1:0]         rob_addr,
    input  logic [2:0]                rob_funct3,
    input  logic [31:0]               rob_value,
    input  logic [NUM_LANES-1:0][7:0] rob_bytes,
    output logic [31:0]               load_data,
    output logic                      exception
);

    word_view_t  ls_word;
    word_view_t  rob_word;
    logic [31:0] ls_result;
    logic [31:0] rob_result;

    // Undo the lane rotation so that byte 0 is the byte at the address
    function automatic word_view_t align_bytes(
        input logic [NUM_LANES-1:0][7:0] lane_bytes,
        input logic [1:0]                off
    );
        word_view_t w;
        logic [1:0] lane;
        for (int k = 0; k < NUM_LANES; k++) begin
            lane       = 2'(k) + off;
            w.bytes[k] = lane_bytes[lane];
        end
        return w;
    endfunction

    // Size select and extension, zero for an unknown funct3
    function automatic logic [31:0] format_load(
        input word_view_t w,
        input logic [2:0] funct3
    );
        logic [31:0] value;
        case (funct3)
            F3_B:    value = {{24{w.bytes[0][7]}}, w.bytes[0]};
            F3_H:    value = {{16{w.halves[0][15]}}, w.halves[0]};
            F3_W:    value = w;
            F3_BU:   value = {24'h000000, w.bytes[0]};
            F3_HU:   value = {16'h0000, w.halves[0]};
            default: value = 32'h00000000;
        endcase
        return value;
    endfunction

    assign ls_word    = align_bytes(ls_bytes, ls_addr[1:0]);
    assign rob_word   = align_bytes(rob_bytes, rob_addr[1:0]);
    assign ls_result  = format_load(ls_word, ls_funct3);
    assign rob_result = format_load(rob_word, rob_funct3);

    // Both results are held for exactly one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            load_data <= 32'h00000000;
            exception <= 1'b0;
        end else begin
            load_data <= ls_read ? ls_result : 32'h00000000;
            exception <= rob_read && (rob_result != rob_value); // Stale value at commit
        end
    end

endmodule

// ==== byte_bank.sv ====
`timescale 1ns/100ps

module byte_bank #(
    parameter int IDX_W = 9
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_index,
    input  logic [7:0]       wr_byte,
    input  logic [IDX_W-1:0] rd_index_a,
    input  logic [IDX_W-1:0] rd_index_b,
    output logic [7:0]       rd_byte_a,
    output logic [7:0]       rd_byte_b
);

    localparam int DEPTH = 1 << IDX_W;

    logic [7:0] mem [DEPTH];

    // Whole bank is cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_byte;
        end
    end

    // Asynchronous reads, so a read on a store edge sees the old byte
    assign rd_byte_a = mem[rd_index_a]; // Speculative load
    assign rd_byte_b = mem[rd_index_b]; // Commit check

endmodule

// ==== access_steer.sv ====
`timescale 1ns/100ps

module access_steer import dmem_pkg::*; #(
    parameter int ADDR_W = 11
) (
    input  logic                             store_en,
    input  logic [ADDR_W-1:0]                store_addr,
    input  logic [2:0]                       store_funct3,
    input  logic [31:0]                      store_data,
    input  logic [ADDR_W-1:0]                ls_addr,
    input  logic [ADDR_W-1:0]                rob_addr,
    output logic [NUM_LANES-1:0]             wr_en,
    output logic [NUM_LANES-1:0][ADDR_W-3:0] wr_index,
    output logic [NUM_LANES-1:0][7:0]        wr_byte,
    output logic [NUM_LANES-1:0][ADDR_W-3:0] ls_index,
    output logic [NUM_LANES-1:0][ADDR_W-3:0] rob_index
);

    localparam int IDX_W = ADDR_W - 2;

    logic [NUM_LANES-1:0] size_mask;   // Bytes touched, before rotation
    logic [1:0]           store_off;
    word_view_t           store_view;

    // Bank index for one lane of an access. A lane below the byte offset
    // holds the part of the access that spilled into the next word.
    function automatic logic [IDX_W-1:0] lane_index(
        input logic [ADDR_W-1:0] addr,
        input int                lane
    );
        logic [IDX_W-1:0] word;
        word = addr[ADDR_W-1:2];
        if (lane < int'(addr[1:0])) begin
            word = word + 1'b1;        // Wraps at the top of memory
        end
        return word;
    endfunction

    assign store_off  = store_addr[1:0];
    assign store_view = store_data;

    // Store size decode
    always_comb begin
        size_mask = '0;
        if (store_en) begin
            case (store_funct3)
                F3_B:    size_mask = 4'b0001;
                F3_H:    size_mask = 4'b0011;
                F3_W:    size_mask = 4'b1111;
                default: size_mask = 4'b0000; // Unknown size writes nothing
            endcase
        end
    end

    // Rotate mask and data up by the offset, then pick each lane's word
    always_comb begin
        logic [1:0] src;
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            src             = 2'(lane) - store_off;  // Store byte landing in this lane
            wr_en[lane]     = size_mask[src];
            wr_byte[lane]   = store_view.bytes[src];
            wr_index[lane]  = lane_index(store_addr, lane);
            ls_index[lane]  = lane_index(ls_addr, lane);
            rob_index[lane] = lane_index(rob_addr, lane);
        end
    end

endmodule

// ==== dmem_pkg.sv ====
package dmem_pkg;

    // Load and store size codes, as carried in funct3
    localparam logic [2:0] F3_B  = 3'b000; // LB / SB
    localparam logic [2:0] F3_H  = 3'b001; // LH / SH
    localparam logic [2:0] F3_W  = 3'b010; // LW / SW
    localparam logic [2:0] F3_BU = 3'b100; // LBU
    localparam logic [2:0] F3_HU = 3'b101; // LHU

    // One bank per byte lane of a word
    localparam int NUM_LANES = 4;

    // A data word as seen by the store and load paths.
    // Byte 0 is the least significant byte, which sits at the lowest address.
    typedef union packed {
        logic [NUM_LANES-1:0][7:0] bytes;   // Per-lane view
        logic [1:0][15:0]          halves;  // Halfword view for LH / LHU
    } word_view_t;

endpackage
